/* all.f */
hw/am_pkg.sv
hw/motor_cmd_if.sv
hw/am_regs.sv
hw/step_lut.sv
hw/am_img.sv
hw/am_ctl.sv
hw/motor_drv.sv
hw/am_top.sv
verif/am_checker.sv
verif/am_tb.sv

/* Bender.yml */
package:
  name: am_ctrl

sources:
  - hw/am_pkg.sv
  - hw/motor_cmd_if.sv
  - hw/am_regs.sv
  - hw/step_lut.sv
  - hw/am_img.sv
  - hw/am_ctl.sv
  - hw/motor_drv.sv
  - hw/am_top.sv
  - target: test
    files:
      - verif/am_checker.sv
      - verif/am_tb.sv

/* verif/am_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module am_tb import am_pkg::*; ();
	localparam bit L2R       = 1'b1;
	localparam int N_REL     = 4;
	localparam int N_ABS     = 3;
	localparam int N_IMG     = 3;
	localparam int MAX_STEP  = 40;  // table entries stay below this too
	localparam int MAX_SPEED = 6;
	// two motor moves per image round
	localparam int CYCLE_LIMIT = (N_REL + N_ABS + 2 * N_IMG) * (MAX_STEP * MAX_SPEED + 64) + 1000;

	logic        clk, resetn;
	logic        cfg_wr, cfg_lut;
	logic [3:0]  cfg_addr;
	logic [31:0] cfg_wdata;
	wire  [31:0] cfg_rdata;
	logic        img_pulse;
	logic [3:0]  img_valid; // lo, ro, li, ri
	logic [11:0] img_lo_y, img_ro_y, img_li_y, img_ri_y;
	wire         step_out, dir_out, busy, exe_done;
	logic        idle, still;

	integer      seed = 32'h896;
	int          cycles = 0;
	int          model_pos = 0;
	logic [31:0] lut_model [16];
	int          dst_m, tol_m;

	am_top #(.L2R(L2R)) uut (
		.clk, .resetn, .cfg_wr, .cfg_lut, .cfg_addr, .cfg_wdata, .cfg_rdata, .img_pulse,
		.img_lo_valid(img_valid[3]), .img_lo_y, .img_ro_valid(img_valid[2]), .img_ro_y,
		.img_li_valid(img_valid[1]), .img_li_y, .img_ri_valid(img_valid[0]), .img_ri_y,
		.step_out, .dir_out, .busy, .exe_done
	);

	am_checker chk (.clk, .resetn, .idle, .still, .step_out, .dir_out, .busy, .exe_done);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cycles <= cycles + 1;

	initial begin
		while (cycles < CYCLE_LIMIT)
			@(posedge clk);
		$display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	// signed step the table gives for a frame error
	function automatic int frame_step(input int err);
		int idx;
		int mag;
		idx = (err < 0) ? -err : err;
		if (idx > 15)
			idx = 15; // clipped to last entry
		mag = int'(lut_model[idx]);
		return ((err < 0) == L2R) ? -mag : mag;
	endfunction

	function automatic int far_centre();
		int e;
		e = rand_range(tol_m + 1, 25);
		if (rand_range(0, 1) == 1)
			e = -e;
		return dst_m - e;
	endfunction

	task automatic write_reg(input logic lut, input logic [3:0] addr, input logic [31:0] data);
		@(posedge clk);
		cfg_wr    <= 1'b1;
		cfg_lut   <= lut;
		cfg_addr  <= addr;
		cfg_wdata <= data;
		@(posedge clk);
		cfg_wr <= 1'b0;
	endtask

	task automatic read_reg(input logic lut, input logic [3:0] addr, output logic [31:0] data);
		@(posedge clk);
		cfg_lut  <= lut;
		cfg_addr <= addr;
		@(negedge clk);
		data = cfg_rdata;
	endtask

	task automatic read_pos(output int p);
		logic [31:0] d;
		read_reg(1'b0, REG_POS, d);
		p = $signed(d);
	endtask

	// edges spread around the centre, returns the model error
	task automatic send_frame(input logic [3:0] valid, input int centre, output int err);
		int a, b, r;
		a = rand_range(0, 50);
		b = rand_range(0, 50);
		r = rand_range(0, 3);
		@(posedge clk);
		img_pulse <= 1'b1;
		img_valid <= valid;
		img_lo_y  <= 12'(centre - a);
		img_ro_y  <= 12'(centre + a);
		img_li_y  <= 12'(centre - b);
		img_ri_y  <= 12'(centre + b + r);
		@(posedge clk);
		img_pulse <= 1'b0;
		err = dst_m - ((4 * centre + r) >> 2);
	endtask

	task automatic wait_result();
		repeat (4) @(posedge clk); // result and motor command land by now
		@(negedge clk);
	endtask

	task automatic run_move(input string name, input move_mode_e mode, input int value);
		int delta, up0, down0, pos;
		delta = (mode == MODE_ABS) ? value - model_pos : value;
		write_reg(1'b0, REG_SPEED, 32'(rand_range(1, MAX_SPEED)));
		write_reg(1'b0, REG_STEP, 32'(value));
		up0   = chk.pos_cnt;
		down0 = chk.neg_cnt;
		write_reg(1'b0, REG_CTRL, 32'(mode));
		@(posedge clk); // go clears exe_done here
		@(negedge clk);
		while (!exe_done)
			@(negedge clk);
		model_pos = model_pos + delta;
		read_pos(pos);
		chk.compare($sformatf("%s position", name), model_pos, pos);
		chk.compare($sformatf("%s up steps", name), (delta > 0) ? delta : 0, chk.pos_cnt - up0);
		chk.compare($sformatf("%s down steps", name), (delta < 0) ? -delta : 0,
			chk.neg_cnt - down0);
	endtask

	task automatic settle_frame();
		int err;
		send_frame(4'hf, dst_m, err);
		wait_result();
		chk.compare("img settle frame", 1, exe_done);
	endtask

	initial begin
		int i, err, pos, step_a, step_b, up0, down0;
		logic [31:0] rd;
		resetn    = 1'b0;
		cfg_wr    = 1'b0;
		cfg_lut   = 1'b0;
		cfg_addr  = '0;
		cfg_wdata = '0;
		img_pulse = 1'b0;
		img_valid = '0;
		img_lo_y  = '0;
		img_ro_y  = '0;
		img_li_y  = '0;
		img_ri_y  = '0;
		idle      = 1'b1;
		still     = 1'b0;
		repeat (4) @(posedge clk);
		resetn <= 1'b1;

		for (i = 0; i < 16; i++) begin
			lut_model[i] = 32'(rand_range(8, MAX_STEP - 1));
			write_reg(1'b1, REG_LUT_BASE + 4'(i), lut_model[i]);
		end
		for (i = 0; i < 16; i++) begin
			read_reg(1'b1, REG_LUT_BASE + 4'(i), rd);
			chk.compare("table readback", lut_model[i], rd);
		end
		@(posedge clk);
		idle <= 1'b0;

		for (i = 0; i < N_REL; i++)
			run_move("rel move", MODE_REL, rand_range(-MAX_STEP, MAX_STEP));
		for (i = 0; i < N_ABS; i++)
			run_move("abs move", MODE_ABS, model_pos + rand_range(-MAX_STEP, MAX_STEP));

		dst_m = rand_range(1000, 3000);
		tol_m = rand_range(1, 4);
		write_reg(1'b0, REG_DST, dst_m);
		write_reg(1'b0, REG_TOL, tol_m);
		write_reg(1'b0, REG_SPEED, 32'(rand_range(3, MAX_SPEED)));
		write_reg(1'b0, REG_CTRL, 32'(MODE_IMG));

		for (i = 0; i < N_IMG; i++) begin
			@(posedge clk);
			still <= 1'b1;
			send_frame(4'hf, dst_m + rand_range(-tol_m, tol_m), err);
			wait_result();
			chk.compare("img frame in tolerance", 1, exe_done);
			send_frame(~(4'b1 << rand_range(0, 3)), dst_m + 20, err); // one edge lost
			wait_result();
			chk.compare("img invalid frame", 0, exe_done);
			repeat (2) @(posedge clk);
			still <= 1'b0;

			// idle motor, one frame off target
			send_frame(4'hf, far_centre(), err);
			step_a = frame_step(err);
			wait_result();
			chk.compare("img start busy", 1, busy);
			while (busy)
				@(negedge clk);
			model_pos = model_pos + step_a;
			read_pos(pos);
			chk.compare("img move position", model_pos, pos);
			chk.compare("img move not done", 0, exe_done);
			settle_frame();

			// second frame lands while running
			up0   = chk.pos_cnt;
			down0 = chk.neg_cnt;
			send_frame(4'hf, far_centre(), err);
			step_a = frame_step(err);
			wait_result();
			chk.compare("img run direction", step_a < 0, dir_out);
			send_frame(4'hf, far_centre(), err);
			step_b = frame_step(err);
			wait_result();
			model_pos = model_pos + (chk.pos_cnt - up0) - (chk.neg_cnt - down0);
			if ((step_b < 0) == (step_a < 0))
				model_pos = model_pos + step_b; // remain change, else stopped here
			while (busy)
				@(negedge clk);
			read_pos(pos);
			chk.compare("img retarget position", model_pos, pos);
			settle_frame();
		end

		repeat (4) @(posedge clk);
		$display("errors: %0d mismatches, %0d other failures", chk.mismatches, chk.failures);
		if (chk.mismatches + chk.failures == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/am_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module am_checker (
	input wire clk,
	input wire resetn,
	input wire idle,      // nothing may move or finish yet
	input wire still,     // frame under test must not move the motor
	input wire step_out,
	input wire dir_out,
	input wire busy,
	input wire exe_done
);
	int   pos_cnt    = 0; // step pulses with dir_out low
	int   neg_cnt    = 0;
	int   mismatches = 0;
	int   failures   = 0;
	logic done_q     = 1'b0;

	task automatic compare(input string name, input logic signed [63:0] expected,
			input logic signed [63:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
			mismatches = mismatches + 1;
		end
	endtask

	task automatic report(input string what);
		$display("error at %0t: %s", $time, what);
		failures = failures + 1;
	endtask

	always @(posedge clk) begin
		if (resetn) begin
			done_q <= exe_done;
			if (step_out && !dir_out)
				pos_cnt <= pos_cnt + 1;
			if (step_out && dir_out)
				neg_cnt <= neg_cnt + 1;
			if (idle && (step_out || busy || exe_done))
				report("motor or exe_done active before the first move");
			if (still && (step_out || busy))
				report("motor moved on a frame that should cause no motion");
			if (exe_done && !done_q && busy)
				report("exe_done rose while the motor was still busy");
		end
	end

endmodule

`default_nettype wire

/* hw/am_top.sv */
`timescale 1ns/1ps
`default_nettype none

module am_top import am_pkg::*; #(
	parameter int IMG_HW  = 12,
	parameter int STEP_W  = 32,
	parameter int SPEED_W = 16,
	parameter int LUT_AW  = 4,
	parameter bit L2R     = 1'b1
) (
	input  wire               clk,
	input  wire               resetn,
	input  wire               cfg_wr,
	input  wire               cfg_lut,
	input  wire [3:0]         cfg_addr,
	input  wire [31:0]        cfg_wdata,
	output wire [31:0]        cfg_rdata,
	input  wire               img_pulse,
	input  wire               img_lo_valid,
	input  wire [IMG_HW-1:0]  img_lo_y,
	input  wire               img_ro_valid,
	input  wire [IMG_HW-1:0]  img_ro_y,
	input  wire               img_li_valid,
	input  wire [IMG_HW-1:0]  img_li_y,
	input  wire               img_ri_valid,
	input  wire [IMG_HW-1:0]  img_ri_y,
	output wire               step_out,
	output wire               dir_out,
	output wire               busy,
	output wire               exe_done
);
	motor_cmd_if #(.STEP_W(STEP_W), .SPEED_W(SPEED_W)) motor ();

	move_mode_e               mode;
	logic [SPEED_W-1:0]       speed;
	logic signed [STEP_W-1:0] step;
	logic [IMG_HW-1:0]        dst, tol;
	logic                     go, arm;
	logic                     lut_we, rd_en;
	logic [LUT_AW-1:0]        lut_waddr, rd_addr;
	logic [STEP_W-1:0]        lut_wdata, rd_data;
	logic                     res_pulse, res_ok, res_start;
	logic signed [STEP_W-1:0] res_step;

	assign busy = motor.running;

	am_regs #(.IMG_HW(IMG_HW), .STEP_W(STEP_W), .SPEED_W(SPEED_W), .LUT_AW(LUT_AW)) u_regs (
		.clk, .resetn, .cfg_wr, .cfg_lut, .cfg_addr, .cfg_wdata, .cfg_rdata,
		.position(motor.position), .running(motor.running), .exe_done,
		.mode, .speed, .step, .dst, .tol, .go, .lut_we, .lut_waddr, .lut_wdata
	);

	step_lut #(.LUT_AW(LUT_AW), .STEP_W(STEP_W)) u_lut (
		.clk, .we(lut_we), .waddr(lut_waddr), .wdata(lut_wdata),
		.rd_en, .rd_addr, .rd_data
	);

	am_img #(.IMG_HW(IMG_HW), .STEP_W(STEP_W), .LUT_AW(LUT_AW), .L2R(L2R)) u_img (
		.clk, .resetn, .arm, .dst, .tol, .img_pulse,
		.img_lo_valid, .img_lo_y, .img_ro_valid, .img_ro_y,
		.img_li_valid, .img_li_y, .img_ri_valid, .img_ri_y,
		.running(motor.running), .rd_en, .rd_addr, .rd_data,
		.o_pulse(res_pulse), .o_step(res_step), .o_ok(res_ok), .o_should_start(res_start)
	);

	am_ctl #(.STEP_W(STEP_W), .SPEED_W(SPEED_W)) u_ctl (
		.clk, .resetn, .mode, .speed, .step, .go,
		.img_pulse_res(res_pulse), .img_step(res_step), .img_ok(res_ok),
		.img_should_start(res_start), .img_arm(arm), .exe_done, .motor(motor.ctl)
	);

	motor_drv #(.STEP_W(STEP_W), .SPEED_W(SPEED_W)) u_drv (
		.clk, .resetn, .motor(motor.drv), .step_out, .dir_out
	);

endmodule

`default_nettype wire

/* hw/motor_drv.sv */
`timescale 1ns/1ps
`default_nettype none

module motor_drv #(
	parameter int STEP_W  = 32,
	parameter int SPEED_W = 16
) (
	input  wire       clk,
	input  wire       resetn,
	motor_cmd_if.drv  motor,
	output logic      step_out,
	output logic      dir_out
);
	logic                     running;
	logic                     dir;      // 1 toward negative
	logic [STEP_W-1:0]        remain;
	logic [SPEED_W-1:0]       spd;
	logic [SPEED_W-1:0]       div;
	logic signed [STEP_W-1:0] position;
	logic signed [STEP_W-1:0] delta;

	function automatic logic [STEP_W-1:0] mag(input logic signed [STEP_W-1:0] v);
		return v[STEP_W-1] ? -v : v;
	endfunction

	assign delta = motor.abs ? motor.step - position : motor.step;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			running  <= 1'b0;
			dir      <= 1'b0;
			remain   <= '0;
			div      <= '0;
			position <= '0;
			step_out <= 1'b0;
		end else begin
			step_out <= 1'b0;
			if (motor.start) begin
				running <= 1'b1;
				dir     <= delta[STEP_W-1];
				remain  <= mag(delta);
				div     <= '0;
			end else if (motor.stop) begin
				running <= 1'b0;
				remain  <= '0;
			end else if (motor.mod_remain) begin
				remain <= mag(motor.new_remain); // same direction only
			end else if (running) begin
				if (remain == '0)
					running <= 1'b0;
				else if (div + 1'b1 >= spd) begin  // speed 0 acts as 1
					div      <= '0;
					step_out <= 1'b1;
					remain   <= remain - 1'b1;
					position <= dir ? position - 1'b1 : position + 1'b1;
				end else
					div <= div + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (motor.start)
			spd <= motor.speed;
	end

	assign dir_out        = dir;
	assign motor.running  = running;
	assign motor.rt_dir   = dir;
	assign motor.position = position;

endmodule

`default_nettype wire

/* hw/am_ctl.sv */
`timescale 1ns/1ps
`default_nettype none

module am_ctl import am_pkg::*; #(
	parameter int STEP_W  = 32,
	parameter int SPEED_W = 16
) (
	input  wire                       clk,
	input  wire                       resetn,
	input  wire move_mode_e           mode,
	input  wire  [SPEED_W-1:0]        speed,
	input  wire signed [STEP_W-1:0]   step,
	input  wire                       go,
	input  wire                       img_pulse_res,
	input  wire signed [STEP_W-1:0]   img_step,
	input  wire                       img_ok,
	input  wire                       img_should_start,
	output logic                      img_arm,
	output logic                      exe_done,
	motor_cmd_if.ctl                  motor
);
	logic img_mode;
	logic started;
	logic run_over;  // our move has been seen running
	logic want_neg;

	assign img_mode = (mode == MODE_IMG);
	assign img_arm  = img_mode;
	assign want_neg = img_step[STEP_W-1];

	always_ff @(posedge clk) begin
		if (!resetn || go) begin
			started  <= 1'b0;
			run_over <= 1'b0;
		end else begin
			if (motor.start)
				started <= 1'b1;
			if (started && motor.running)
				run_over <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn || go)
			exe_done <= 1'b0;
		else if (img_mode) begin
			if (img_pulse_res)
				exe_done <= img_ok; // last frame decides
		end else if (run_over && !motor.running)
			exe_done <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			motor.start      <= 1'b0;
			motor.stop       <= 1'b0;
			motor.mod_remain <= 1'b0;
		end else begin
			motor.start      <= 1'b0;
			motor.stop       <= 1'b0;
			motor.mod_remain <= 1'b0;
			if (!img_mode) begin
				motor.start <= go;
			end else if (img_pulse_res) begin
				if (img_should_start)
					motor.start <= 1'b1;
				else if (motor.running && (motor.rt_dir != want_neg))
					motor.stop <= 1'b1; // reversal needs a halt first
				else if (motor.running)
					motor.mod_remain <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!img_mode && go) begin
			motor.speed <= speed;
			motor.step  <= step;
			motor.abs   <= (mode == MODE_ABS);
		end else if (img_mode && img_pulse_res) begin
			motor.speed      <= speed;
			motor.step       <= img_step;
			motor.abs        <= 1'b0;
			motor.new_remain <= img_step;
		end
	end

	// driver halts the cycle after a stop
	a_stop_halts: assert property (
		@(posedge clk) disable iff (!resetn)
		motor.stop |=> !motor.running
	) else $error("am_ctl: motor still running after a stop");

endmodule

`default_nettype wire

/* hw/am_img.sv */
`timescale 1ns/1ps
`default_nettype none

module am_img #(
	parameter int IMG_HW = 12,
	parameter int STEP_W = 32,
	parameter int LUT_AW = 4,
	parameter bit L2R    = 1'b1
) (
	input  wire                       clk,
	input  wire                       resetn,
	input  wire                       arm,
	input  wire  [IMG_HW-1:0]         dst,
	input  wire  [IMG_HW-1:0]         tol,
	input  wire                       img_pulse,
	input  wire                       img_lo_valid,
	input  wire  [IMG_HW-1:0]         img_lo_y,
	input  wire                       img_ro_valid,
	input  wire  [IMG_HW-1:0]         img_ro_y,
	input  wire                       img_li_valid,
	input  wire  [IMG_HW-1:0]         img_li_y,
	input  wire                       img_ri_valid,
	input  wire  [IMG_HW-1:0]         img_ri_y,
	input  wire                       running,
	output logic                      rd_en,
	output logic [LUT_AW-1:0]         rd_addr,
	input  wire  [STEP_W-1:0]         rd_data,
	output logic                      o_pulse,
	output logic signed [STEP_W-1:0]  o_step,
	output logic                      o_ok,
	output logic                      o_should_start
);
	localparam int EW = IMG_HW + 1;
	localparam logic [EW-1:0] LUT_LAST = EW'(2**LUT_AW - 1);

	logic [IMG_HW+1:0]    edge_sum;
	logic [IMG_HW-1:0]    centre;
	logic                 s1_v, s1_frame;
	logic signed [EW-1:0] s1_err;
	logic [EW-1:0]        s1_abs;
	logic                 s2_v, s2_frame, s2_ok, s2_neg;
	logic                 neg;

	assign edge_sum = img_lo_y + img_ro_y + img_li_y + img_ri_y;
	assign centre   = edge_sum[IMG_HW+1:2]; // mean of four edges

	// capture
	always_ff @(posedge clk) begin
		if (!resetn)
			s1_v <= 1'b0;
		else
			s1_v <= img_pulse && arm;
	end

	always_ff @(posedge clk) begin
		if (img_pulse) begin
			s1_err   <= $signed({1'b0, dst}) - $signed({1'b0, centre});
			s1_frame <= img_lo_valid && img_ro_valid && img_li_valid && img_ri_valid;
		end
	end

	// address, clipped to last entry
	assign s1_abs  = s1_err[EW-1] ? -s1_err : s1_err;
	assign rd_addr = (s1_abs > LUT_LAST) ? '1 : LUT_AW'(s1_abs);
	assign rd_en   = s1_v;

	always_ff @(posedge clk) begin
		if (!resetn)
			s2_v <= 1'b0;
		else
			s2_v <= s1_v;
	end

	always_ff @(posedge clk) begin
		if (s1_v) begin
			s2_neg   <= s1_err[EW-1];
			s2_frame <= s1_frame;
			s2_ok    <= s1_frame && (s1_abs <= {1'b0, tol});
		end
	end

	// data, sign applied
	assign neg = L2R ? s2_neg : !s2_neg;

	always_ff @(posedge clk) begin
		if (!resetn)
			o_pulse <= 1'b0;
		else
			o_pulse <= s2_v;
	end

	always_ff @(posedge clk) begin
		if (s2_v) begin
			if (!s2_frame)
				o_step <= '0; // bad frame, no motion
			else
				o_step <= neg ? -$signed(rd_data) : $signed(rd_data);
			o_ok           <= s2_ok;
			o_should_start <= s2_frame && !s2_ok && !running;
		end
	end

	// frames must be spaced by at least two cycles
	a_pulse_gap: assert property (
		@(posedge clk) disable iff (!resetn) o_pulse |=> !o_pulse
	) else $error("am_img: back to back results");

endmodule

`default_nettype wire

/* hw/step_lut.sv */
`timescale 1ns/1ps
`default_nettype none

module step_lut #(
	parameter int LUT_AW = 4,
	parameter int STEP_W = 32
) (
	input  wire                clk,
	input  wire                we,
	input  wire [LUT_AW-1:0]   waddr,
	input  wire [STEP_W-1:0]   wdata,
	input  wire                rd_en,
	input  wire [LUT_AW-1:0]   rd_addr,
	output logic [STEP_W-1:0]  rd_data
);
	// step magnitude per absolute error
	logic [STEP_W-1:0] mem [2**LUT_AW];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
		if (rd_en)
			rd_data <= mem[rd_addr]; // held between lookups
	end

	// host rewriting the entry a frame is looking up
	a_no_wr_rd_clash: assert property (
		@(posedge clk) (we && rd_en) |-> (waddr != rd_addr)
	) else $error("step_lut: write and lookup hit index %0d together", waddr);

endmodule

`default_nettype wire

/* hw/am_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module am_regs import am_pkg::*; #(
	parameter int IMG_HW  = 12,
	parameter int STEP_W  = 32,
	parameter int SPEED_W = 16,
	parameter int LUT_AW  = 4
) (
	input  wire                       clk,
	input  wire                       resetn,
	input  wire                       cfg_wr,
	input  wire                       cfg_lut,
	input  wire  [3:0]                cfg_addr,
	input  wire  [31:0]               cfg_wdata,
	output logic [31:0]               cfg_rdata,
	input  wire signed [STEP_W-1:0]   position,
	input  wire                       running,
	input  wire                       exe_done,
	output move_mode_e                mode,
	output logic [SPEED_W-1:0]        speed,
	output logic signed [STEP_W-1:0]  step,
	output logic [IMG_HW-1:0]         dst,
	output logic [IMG_HW-1:0]         tol,
	output logic                      go,
	output logic                      lut_we,
	output logic [LUT_AW-1:0]         lut_waddr,
	output logic [STEP_W-1:0]         lut_wdata
);
	logic              reg_wr;
	logic [LUT_AW-1:0] lut_idx;
	logic [STEP_W-1:0] lut_copy [2**LUT_AW]; // readback copy of the step table

	assign reg_wr  = cfg_wr && !cfg_lut;
	assign lut_idx = LUT_AW'(cfg_addr - REG_LUT_BASE);

	assign lut_we    = cfg_wr && cfg_lut;
	assign lut_waddr = lut_idx;
	assign lut_wdata = cfg_wdata[STEP_W-1:0];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			mode  <= MODE_REL;
			speed <= SPEED_W'(1);
			step  <= '0;
			dst   <= '0;
			tol   <= '0;
			go    <= 1'b0;
		end else begin
			go <= reg_wr && (cfg_addr == REG_CTRL); // lands with the new mode
			if (reg_wr) begin
				case (cfg_addr)
					REG_CTRL:  mode  <= move_mode_e'(cfg_wdata[1:0]);
					REG_SPEED: speed <= cfg_wdata[SPEED_W-1:0];
					REG_STEP:  step  <= $signed(cfg_wdata[STEP_W-1:0]);
					REG_DST:   dst   <= cfg_wdata[IMG_HW-1:0];
					REG_TOL:   tol   <= cfg_wdata[IMG_HW-1:0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (lut_we)
			lut_copy[lut_idx] <= lut_wdata;
	end

	always_comb begin
		cfg_rdata = '0;
		if (cfg_lut) begin
			cfg_rdata = 32'(lut_copy[lut_idx]);
		end else begin
			case (cfg_addr)
				REG_CTRL:   cfg_rdata = 32'(mode);
				REG_SPEED:  cfg_rdata = 32'(speed);
				REG_STEP:   cfg_rdata = 32'(step);
				REG_DST:    cfg_rdata = 32'(dst);
				REG_TOL:    cfg_rdata = 32'(tol);
				REG_STATUS: cfg_rdata = {30'd0, exe_done, running};
				REG_POS:    cfg_rdata = 32'(position); // sign extended
				default:    cfg_rdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/motor_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface motor_cmd_if #(
	parameter int STEP_W  = 32,
	parameter int SPEED_W = 16
);
	// command pulses, fields valid in the pulse cycle
	logic                     start;
	logic                     stop;
	logic                     mod_remain;
	logic [SPEED_W-1:0]       speed;
	logic signed [STEP_W-1:0] step;
	logic                     abs;        // step is a target position
	logic signed [STEP_W-1:0] new_remain;

	logic                     running;
	logic                     rt_dir;     // 1 while stepping toward negative
	logic signed [STEP_W-1:0] position;

	modport ctl (
		output start, stop, mod_remain, speed, step, abs, new_remain,
		input  running, rt_dir, position
	);

	modport drv (
		input  start, stop, mod_remain, speed, step, abs, new_remain,
		output running, rt_dir, position
	);
endinterface

`default_nettype wire

/* hw/am_pkg.sv */
`default_nettype none

package am_pkg;

	// word addresses on the cfg bus
	localparam logic [3:0] REG_CTRL     = 4'h0; // mode in [1:0], write fires go
	localparam logic [3:0] REG_SPEED    = 4'h1; // cycles per step
	localparam logic [3:0] REG_STEP     = 4'h2; // signed step or abs target
	localparam logic [3:0] REG_DST      = 4'h3;
	localparam logic [3:0] REG_TOL      = 4'h4;
	localparam logic [3:0] REG_STATUS   = 4'h5; // {exe_done, running}
	localparam logic [3:0] REG_POS      = 4'h6;

	// table space, only while cfg_lut is high
	localparam logic [3:0] REG_LUT_BASE = 4'h0;

	typedef enum logic [1:0] {
		MODE_REL = 2'd0,
		MODE_ABS = 2'd1,
		MODE_IMG = 2'd2
	} move_mode_e;

endpackage

`default_nettype wire
